/* sources.f */
rtl/cacheGeomPkg.sv
rtl/flushCtlPkg.sv
rtl/cacheLineIf.sv
rtl/cacheStore.sv
rtl/lineSnapshot.sv
rtl/flushSequencer.sv
rtl/shadowMem.sv
rtl/shadowCacheTop.sv
verif/shadowCacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f sources.f --top-module shadowCacheTbTop -Mdir "$OBJ" -o simTb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/simTb" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Everything OK" "$LOG"; then
  echo "run passed"
  exit 0
fi
echo "run failed, see $LOG"
exit 1

/* verif/shadowCacheTb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench top: clock, reset, reference model, stimulus, checks, watchdog
////////////////////////////////////////////////////////////////////////////

module shadowCacheTbTop;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IndexBits = cacheGeomPkg::DefIndexBits;
  localparam int TagBits   = cacheGeomPkg::DefTagBits;
  localparam int DataBits  = cacheGeomPkg::DefDataBits;
  localparam int AdrBits   = cacheGeomPkg::DefAddrBits;
  localparam int NumLines  = cacheGeomPkg::DefNumLines;
  localparam int MemWords  = cacheGeomPkg::DefMemWords;
  localparam int ClkPeriod = 40;

  // stimulus sizes, also used to size the watchdog
  localparam int InitReads  = 4;
  localparam int PairRounds = 8;
  localparam int RandOpsA   = 40;
  localparam int RandOpsB   = 20;
  localparam int NumFlushes = 3;
  // cycles: reads and memory checks take 2, writes 1, each round of pairs 10
  localparam int NumOps = 3 + 2 * InitReads + 10 * PairRounds + 2 * (RandOpsA + RandOpsB)
                        + 3 * 2 * MemWords + 2 * NumLines + 1;
  localparam int TimeoutCycles = NumOps + NumFlushes * (NumLines + 4) + 50;

  logic                 clk;
  logic                 arstN;
  logic                 start;
  flushCtlPkg::cacheOpE op;
  logic [AdrBits-1:0]   addr;
  logic [DataBits-1:0]  wdata;
  logic [AdrBits-1:0]   memAddr;
  logic                 done;
  logic                 busy;
  logic                 readValid;
  logic                 readHit;
  logic [DataBits-1:0]  readData;
  logic [DataBits-1:0]  memData;

  // expected DUT state after the last rising edge, set on the falling edge
  logic                expBusy;
  logic                expDone;
  logic                expReadValid;
  logic                expReadHit;
  logic [DataBits-1:0] expReadData;
  logic                expMemValid;
  logic [DataBits-1:0] expMemData;

  // reference model of the cache lines and the shadow memory
  logic [TagBits-1:0]  cTag [NumLines];
  logic [DataBits-1:0] cData [NumLines];
  bit                  cValid [NumLines];
  bit                  cDirty [NumLines];
  logic [DataBits-1:0] memModel [MemWords];
  bit                  memWritten [MemWords];

  shadowCacheTop #(.IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits))
    shadowCacheTop_i (
    .clk, .arstN, .start, .op, .addr, .wdata, .memAddr,
    .done, .busy, .readValid, .readHit, .readData, .memData
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // watchdog sized from the test length above
  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("watchdog expired after %0d clock cycles without the test finishing",
             TimeoutCycles);
    $display("Something failed");
    $fatal(1, "timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks against the model
  ////////////////////////////////////////////////////////////////////////////

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    $display("ERR %0t %s expected %0h actual %0h", $time, name, expVal, actVal);
    $display("Something failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  busyCheck: assert property (@(posedge clk) disable iff (!arstN) busy == expBusy)
    else reportMismatch("busy", 32'(expBusy), 32'($sampled(busy)));
  // done must pulse once, at the exact cycle
  doneCheck: assert property (@(posedge clk) disable iff (!arstN) done == expDone)
    else reportMismatch("done", 32'(expDone), 32'($sampled(done)));
  readValidCheck: assert property (@(posedge clk) disable iff (!arstN)
    readValid == expReadValid)
    else reportMismatch("readValid", 32'(expReadValid), 32'($sampled(readValid)));
  readHitCheck: assert property (@(posedge clk) disable iff (!arstN)
    expReadValid |-> readHit == expReadHit)
    else reportMismatch("readHit", 32'(expReadHit), 32'($sampled(readHit)));
  // data only compared on a hit
  readDataCheck: assert property (@(posedge clk) disable iff (!arstN)
    expReadValid && expReadHit |-> readData == expReadData)
    else reportMismatch("readData", 32'(expReadData), 32'($sampled(readData)));
  memDataCheck: assert property (@(posedge clk) disable iff (!arstN)
    expMemValid |-> memData == expMemData)
    else reportMismatch("memData", 32'(expMemData), 32'($sampled(memData)));

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [TagBits-1:0] tagOf(input logic [AdrBits-1:0] adr);
    return adr[AdrBits-1:IndexBits];
  endfunction

  function automatic logic [IndexBits-1:0] idxOf(input logic [AdrBits-1:0] adr);
    return adr[IndexBits-1:0];
  endfunction

  function automatic logic [AdrBits-1:0] randomAdr();
    return AdrBits'($urandom_range(0, MemWords - 1));
  endfunction

  // next falling edge, inputs quiet and one-shot expectations cleared
  task automatic nextCycle();
    @(negedge clk);
    op           = flushCtlPkg::opNone;
    start        = 1'b0;
    expReadValid = 1'b0;
    expMemValid  = 1'b0;
  endtask

  task automatic writeWord(input logic [AdrBits-1:0] adr, input logic [DataBits-1:0] data);
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] idx;
    nextCycle();
    op    = flushCtlPkg::opWrite;
    addr  = adr;
    wdata = data;
    tag   = tagOf(adr);
    idx   = idxOf(adr);
    // old dirty word of another tag goes to memory
    if (cValid[idx] && cDirty[idx] && cTag[idx] != tag) begin
      memModel[{cTag[idx], idx}]   = cData[idx];
      memWritten[{cTag[idx], idx}] = 1'b1;
    end
    cTag[idx]   = tag;
    cData[idx]  = data;
    cValid[idx] = 1'b1;
    cDirty[idx] = 1'b1;
  endtask

  task automatic readWord(input logic [AdrBits-1:0] adr);
    logic [IndexBits-1:0] idx;
    nextCycle();
    op   = flushCtlPkg::opRead;
    addr = adr;
    idx  = idxOf(adr);
    // response is registered, expected one cycle later
    nextCycle();
    expReadValid = 1'b1;
    expReadHit   = cValid[idx] && (cTag[idx] == tagOf(adr));
    expReadData  = cData[idx];
  endtask

  task automatic checkMemWord(input logic [AdrBits-1:0] adr);
    nextCycle();
    memAddr = adr;
    nextCycle();
    // never-written words hold no known value
    expMemValid = memWritten[adr];
    expMemData  = memModel[adr];
  endtask

  task automatic dumpMemory();
    for (int a = 0; a < MemWords; a++) begin
      checkMemWord(AdrBits'(a));
    end
  endtask

  // flush result: every valid dirty line lands in memory and turns clean
  function automatic void applyFlush();
    for (int i = 0; i < NumLines; i++) begin
      if (cValid[i] && cDirty[i]) begin
        memModel[{cTag[i], IndexBits'(i)}]   = cData[i];
        memWritten[{cTag[i], IndexBits'(i)}] = 1'b1;
        cDirty[i] = 1'b0;
      end
    end
  endfunction

  // random op and start while busy, all of which the DUT must ignore
  task automatic driveNoise();
    case ($urandom_range(0, 2))
      0: op = flushCtlPkg::opNone;
      1: op = flushCtlPkg::opRead;
      default: op = flushCtlPkg::opWrite;
    endcase
    addr  = randomAdr();
    wdata = DataBits'($urandom());
    start = 1'($urandom_range(0, 1));
  endtask

  task automatic runFlush();
    nextCycle();
    start = 1'b1;
    applyFlush();
    // capture cycle after the start edge
    nextCycle();
    expBusy = 1'b1;
    driveNoise();
    // one walk cycle per line
    repeat (NumLines) begin
      nextCycle();
      driveNoise();
    end
    nextCycle();
    expDone = 1'b1;
    driveNoise();
    nextCycle();
    expBusy = 1'b0;
    expDone = 1'b0;
  endtask

  task automatic randomOps(input int count);
    for (int i = 0; i < count; i++) begin
      if ($urandom_range(0, 1) == 1) begin
        writeWord(randomAdr(), DataBits'($urandom()));
      end else begin
        readWord(randomAdr());
      end
    end
  endtask

  // lines stay valid after a flush, so valid ones must still hit
  task automatic readCachedLines();
    for (int i = 0; i < NumLines; i++) begin
      if (cValid[i]) begin
        readWord({cTag[i], IndexBits'(i)});
      end else begin
        readWord(AdrBits'(i));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [AdrBits-1:0] a;
    logic [AdrBits-1:0] b;
    void'($urandom(85114));
    arstN        = 1'b0;
    start        = 1'b0;
    op           = flushCtlPkg::opNone;
    addr         = '0;
    wdata        = '0;
    memAddr      = '0;
    expBusy      = 1'b0;
    expDone      = 1'b0;
    expReadValid = 1'b0;
    expReadHit   = 1'b0;
    expReadData  = '0;
    expMemValid  = 1'b0;
    expMemData   = '0;
    for (int i = 0; i < NumLines; i++) begin
      cValid[i] = 1'b0;
      cDirty[i] = 1'b0;
    end
    for (int i = 0; i < MemWords; i++) begin
      memWritten[i] = 1'b0;
    end
    repeat (3) @(negedge clk);
    arstN = 1'b1;

    // empty cache misses everywhere
    repeat (InitReads) readWord(randomAdr());

    // hit, miss on another tag, then eviction of the first word
    for (int r = 0; r < PairRounds; r++) begin
      a = randomAdr();
      b = {tagOf(a) + TagBits'(1), idxOf(a)};
      writeWord(a, DataBits'($urandom()));
      readWord(a);
      readWord(b);
      writeWord(b, DataBits'($urandom()));
      checkMemWord(a);
      readWord(b);
    end

    randomOps(RandOpsA);
    runFlush();
    dumpMemory();
    readCachedLines();

    // second round, then a flush with nothing dirty left
    randomOps(RandOpsB);
    runFlush();
    dumpMemory();
    runFlush();
    dumpMemory();

    nextCycle();
    $display("Everything OK");
    $finish;
  end

endmodule

/* rtl/shadowCacheTop.sv */
////////////////////////////////////////////////////////////////////////////
// write-back cache with flush engine and shadow memory, top level
////////////////////////////////////////////////////////////////////////////

module shadowCacheTop #(
  parameter int IndexBits = cacheGeomPkg::DefIndexBits,
  parameter int TagBits   = cacheGeomPkg::DefTagBits,
  parameter int DataBits  = cacheGeomPkg::DefDataBits
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         start,
  input  flushCtlPkg::cacheOpE         op,
  input  logic [TagBits+IndexBits-1:0] addr,
  input  logic [DataBits-1:0]          wdata,
  input  logic [TagBits+IndexBits-1:0] memAddr,
  output logic                         done,
  output logic                         busy,
  output logic                         readValid,
  output logic                         readHit,
  output logic [DataBits-1:0]          readData,
  output logic [DataBits-1:0]          memData
);

  localparam int NumLines = 2 ** IndexBits;
  localparam int AdrBits  = TagBits + IndexBits;

  logic                 capture;
  logic                 cleanEn;
  logic [IndexBits-1:0] cleanIndex;
  logic                 evictEn;
  logic [AdrBits-1:0]   evictAdr;
  logic [DataBits-1:0]  evictData;
  logic                 walkEn;
  logic [AdrBits-1:0]   walkAdr;
  logic [DataBits-1:0]  walkData;

  // one live line and one frozen image per index
  cacheLineIf #(.TagBits(TagBits), .DataBits(DataBits)) lineBus [NumLines] ();
  lineImageIf #(.IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits))
    imageBus [NumLines] ();

  cacheStore #(.IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits)) cacheStore_i (
    .clk, .arstN, .op, .addr, .wdata, .busy, .cleanEn, .cleanIndex,
    .readValid, .readHit, .readData, .evictEn, .evictAdr, .evictData,
    .lines(lineBus)
  );

  for (genvar g = 0; g < NumLines; g++) begin : gSnap
    lineSnapshot #(
      .Index(g), .IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits)
    ) lineSnapshot_i (
      .clk, .arstN, .capture, .line(lineBus[g]), .image(imageBus[g])
    );
  end

  flushSequencer #(.IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits))
    flushSequencer_i (
    .clk, .arstN, .start, .done, .busy, .capture, .cleanEn, .cleanIndex,
    .walkEn, .walkAdr, .walkData, .images(imageBus)
  );

  shadowMem #(.IndexBits(IndexBits), .TagBits(TagBits), .DataBits(DataBits)) shadowMem_i (
    .clk, .evictEn, .evictAdr, .evictData, .walkEn, .walkAdr, .walkData,
    .memAddr, .memData
  );

endmodule

/* rtl/shadowMem.sv */
////////////////////////////////////////////////////////////////////////////
// shadow memory image, eviction and walk write ports, one read port
////////////////////////////////////////////////////////////////////////////

module shadowMem #(
  parameter int IndexBits = 3,
  parameter int TagBits   = 3,
  parameter int DataBits  = 16
) (
  input  logic                         clk,
  input  logic                         evictEn,
  input  logic [TagBits+IndexBits-1:0] evictAdr,
  input  logic [DataBits-1:0]          evictData,
  input  logic                         walkEn,
  input  logic [TagBits+IndexBits-1:0] walkAdr,
  input  logic [DataBits-1:0]          walkData,
  input  logic [TagBits+IndexBits-1:0] memAddr,
  output logic [DataBits-1:0]          memData
);

  localparam int Depth = 2 ** (TagBits + IndexBits);

  logic [DataBits-1:0] mem [Depth];

  // walk port wins, though both never fire together
  always_ff @(posedge clk) begin
    if (walkEn) begin
      mem[walkAdr] <= walkData;
    end else if (evictEn) begin
      mem[evictAdr] <= evictData;
    end
  end

  // inspection port, old word on a same-edge write
  always_ff @(posedge clk) begin
    memData <= mem[memAddr];
  end

  // evictions come from the cache, walks only while it is frozen
  noDualWrite: assert property (@(posedge clk) !(evictEn && walkEn));

endmodule

/* rtl/flushSequencer.sv */
////////////////////////////////////////////////////////////////////////////
// flush FSM: snapshot all lines, write dirty ones to memory, clean them
////////////////////////////////////////////////////////////////////////////

module flushSequencer #(
  parameter int IndexBits = 3,
  parameter int TagBits   = 3,
  parameter int DataBits  = 16
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  logic                         start,
  output logic                         done,
  output logic                         busy,
  output logic                         capture,
  output logic                         cleanEn,
  output logic [IndexBits-1:0]         cleanIndex,
  output logic                         walkEn,
  output logic [TagBits+IndexBits-1:0] walkAdr,
  output logic [DataBits-1:0]          walkData,
  lineImageIf.walk                     images [2**IndexBits]
);

  localparam int NumLines = 2 ** IndexBits;
  localparam int AdrBits  = TagBits + IndexBits;

  flushCtlPkg::flushStateE state;
  flushCtlPkg::flushStateE stateNext;

  logic [IndexBits-1:0] walkIdx;
  logic                 lastLine;

  // images gathered into plain arrays so the counter can select one
  logic [AdrBits-1:0]  imgAdr  [NumLines];
  logic [DataBits-1:0] imgData [NumLines];
  logic [NumLines-1:0] imgValid;
  logic [NumLines-1:0] imgDirty;

  for (genvar g = 0; g < NumLines; g++) begin : gImgIn
    assign imgAdr[g]   = images[g].adr;
    assign imgData[g]  = images[g].data;
    assign imgValid[g] = images[g].valid;
    assign imgDirty[g] = images[g].dirty;
  end

  assign lastLine = (walkIdx == IndexBits'(NumLines - 1));

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      // start is only honoured from idle
      flushCtlPkg::fsIdle:    if (start) stateNext = flushCtlPkg::fsCapture;
      flushCtlPkg::fsCapture: stateNext = flushCtlPkg::fsWalk;
      flushCtlPkg::fsWalk:    if (lastLine) stateNext = flushCtlPkg::fsDone;
      flushCtlPkg::fsDone:    stateNext = flushCtlPkg::fsIdle;
      default:                stateNext = flushCtlPkg::fsIdle;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state   <= flushCtlPkg::fsIdle;
      walkIdx <= '0;
    end else begin
      state <= stateNext;
      // one line per walk cycle, restart at line 0 each flush
      if (state == flushCtlPkg::fsCapture) begin
        walkIdx <= '0;
      end else if (state == flushCtlPkg::fsWalk) begin
        walkIdx <= walkIdx + 1'b1;
      end
    end
  end

  assign busy    = (state != flushCtlPkg::fsIdle);
  assign capture = (state == flushCtlPkg::fsCapture);
  assign done    = (state == flushCtlPkg::fsDone);

  // only valid dirty lines reach memory, and the same line is cleaned
  assign walkEn     = (state == flushCtlPkg::fsWalk) && imgValid[walkIdx] && imgDirty[walkIdx];
  assign cleanEn    = walkEn;
  assign cleanIndex = walkIdx;
  assign walkAdr    = imgAdr[walkIdx];
  assign walkData   = imgData[walkIdx];

  // done comes right after the last line is walked, and the cache unfreezes after it
  doneThenIdle: assert property (@(posedge clk) disable iff (!arstN)
    done |-> $past(lastLine) ##1 !busy);

endmodule

/* rtl/lineSnapshot.sv */
////////////////////////////////////////////////////////////////////////////
// captured copy of one cache line and its word address
////////////////////////////////////////////////////////////////////////////

module lineSnapshot #(
  parameter int Index     = 0,
  parameter int IndexBits = 3,
  parameter int TagBits   = 3,
  parameter int DataBits  = 16
) (
  input  logic     clk,
  input  logic     arstN,
  input  logic     capture,
  cacheLineIf.snap line,
  lineImageIf.snap image
);

  logic [TagBits-1:0]  capTag;
  logic [DataBits-1:0] capData;
  logic                capValid;
  logic                capDirty;

  // captured flags, clear until the first flush
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      capValid <= 1'b0;
      capDirty <= 1'b0;
    end else if (capture) begin
      capValid <= line.valid;
      capDirty <= line.dirty;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      capTag  <= line.tag;
      capData <= line.data;
    end
  end

  // word address, captured tag above this line's fixed index
  assign image.adr   = {capTag, IndexBits'(Index)};
  assign image.data  = capData;
  assign image.valid = capValid;
  assign image.dirty = capDirty;

endmodule

/* rtl/cacheStore.sv */
////////////////////////////////////////////////////////////////////////////
// direct-mapped line arrays with read, write, eviction and clean ports
////////////////////////////////////////////////////////////////////////////

module cacheStore #(
  parameter int IndexBits = 3,
  parameter int TagBits   = 3,
  parameter int DataBits  = 16
) (
  input  logic                         clk,
  input  logic                         arstN,
  input  flushCtlPkg::cacheOpE         op,
  input  logic [TagBits+IndexBits-1:0] addr,
  input  logic [DataBits-1:0]          wdata,
  input  logic                         busy,
  input  logic                         cleanEn,
  input  logic [IndexBits-1:0]         cleanIndex,
  output logic                         readValid,
  output logic                         readHit,
  output logic [DataBits-1:0]          readData,
  output logic                         evictEn,
  output logic [TagBits+IndexBits-1:0] evictAdr,
  output logic [DataBits-1:0]          evictData,
  cacheLineIf.store                    lines [2**IndexBits]
);

  localparam int NumLines = 2 ** IndexBits;

  logic [TagBits-1:0]  tagArr  [NumLines];
  logic [DataBits-1:0] dataArr [NumLines];
  logic [NumLines-1:0] validArr;
  logic [NumLines-1:0] dirtyArr;

  logic [TagBits-1:0]   reqTag;
  logic [IndexBits-1:0] reqIndex;
  logic                 wrEn;
  logic                 rdEn;

  // tag is the upper slice, index the lower
  assign {reqTag, reqIndex} = addr;

  // the cache is frozen while a flush runs
  assign wrEn = (op == flushCtlPkg::opWrite) && !busy;
  assign rdEn = (op == flushCtlPkg::opRead) && !busy;

  // old dirty word of another tag goes to memory on the same edge as the write
  assign evictEn   = wrEn && validArr[reqIndex] && dirtyArr[reqIndex]
                     && (tagArr[reqIndex] != reqTag);
  assign evictAdr  = {tagArr[reqIndex], reqIndex};
  assign evictData = dataArr[reqIndex];

  ////////////////////////////////////////////////////////////////////////////
  // line state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validArr <= '0;
      dirtyArr <= '0;
    end else begin
      // clean only happens during a flush, never together with a write
      if (cleanEn) begin
        dirtyArr[cleanIndex] <= 1'b0;
      end
      if (wrEn) begin
        validArr[reqIndex] <= 1'b1;
        dirtyArr[reqIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      tagArr[reqIndex]  <= reqTag;
      dataArr[reqIndex] <= wdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registered read response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readValid <= 1'b0;
      readHit   <= 1'b0;
    end else begin
      readValid <= rdEn;
      if (rdEn) begin
        readHit <= validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
      end
    end
  end

  // word is returned even on a miss
  always_ff @(posedge clk) begin
    if (rdEn) begin
      readData <= dataArr[reqIndex];
    end
  end

  // expose every line to its snapshot
  for (genvar g = 0; g < NumLines; g++) begin : gLineOut
    assign lines[g].tag   = tagArr[g];
    assign lines[g].data  = dataArr[g];
    assign lines[g].valid = validArr[g];
    assign lines[g].dirty = dirtyArr[g];
  end

  // the flush FSM may only clean lines while it holds the cache frozen
  cleanOnlyBusy: assert property (@(posedge clk) disable iff (!arstN) cleanEn |-> busy);

endmodule

/* rtl/cacheLineIf.sv */
////////////////////////////////////////////////////////////////////////////
// cacheLineIf: one stored line; lineImageIf: one captured line image
////////////////////////////////////////////////////////////////////////////

// live contents of one cache line, store side drives
interface cacheLineIf #(
  parameter int TagBits  = 3,
  parameter int DataBits = 16
);
  logic [TagBits-1:0]  tag;
  logic [DataBits-1:0] data;
  logic                valid;
  logic                dirty;

  modport store (output tag, data, valid, dirty);
  modport snap  (input  tag, data, valid, dirty);
endinterface

// frozen line with its full word address, walked by the flush FSM
interface lineImageIf #(
  parameter int IndexBits = 3,
  parameter int TagBits   = 3,
  parameter int DataBits  = 16
);
  logic [TagBits+IndexBits-1:0] adr;
  logic [DataBits-1:0]          data;
  logic                         valid;
  logic                         dirty;

  modport snap (output adr, data, valid, dirty);
  modport walk (input  adr, data, valid, dirty);
endinterface

/* rtl/flushCtlPkg.sv */
////////////////////////////////////////////////////////////////////////////
// cache operation codes and flush FSM states
////////////////////////////////////////////////////////////////////////////

package flushCtlPkg;

  // request on the cache port, sampled every clock
  typedef enum logic [1:0] {
    opNone  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2
  } cacheOpE;

  // flush engine: idle, snapshot all lines, walk them, report done
  typedef enum logic [1:0] {
    fsIdle    = 2'd0,
    fsCapture = 2'd1,
    fsWalk    = 2'd2,
    fsDone    = 2'd3
  } flushStateE;

endpackage

/* rtl/cacheGeomPkg.sv */
////////////////////////////////////////////////////////////////////////////
// default cache geometry and the derived address widths
////////////////////////////////////////////////////////////////////////////

package cacheGeomPkg;

  // index bits select the line, 3 gives 8 lines
  localparam int DefIndexBits = 3;

  // tag bits sit above the index in a word address
  localparam int DefTagBits = 3;

  // width of one data word, one word per line
  localparam int DefDataBits = 16;

  // full word address is tag followed by index
  localparam int DefAddrBits = DefTagBits + DefIndexBits;

  // number of lines in the direct-mapped array
  localparam int DefNumLines = 2 ** DefIndexBits;

  // number of words in the shadow memory image
  localparam int DefMemWords = 2 ** DefAddrBits;

endpackage
